//--- flist.f
+incdir+include
verilog/periph_bus_pkg.sv
verilog/comm_pkg.sv
verilog/comm_mailbox.sv
verilog/cache_sampler.sv
verilog/peripheral_subsystem.sv
tests/tb_clock_gen.sv
tests/tb_peripheral_subsystem.sv

//--- Makefile
# Verilator simulation of the peripheral subsystem
VERILATOR ?= verilator
TOP       ?= tb_peripheral_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^TEST RESULT: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_peripheral_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "peripheral_defs.svh"

module tb_peripheral_subsystem
	import periph_bus_pkg::*;
	import comm_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	// reset, mailbox, control, phase and sampling tests plus a margin
	localparam int TEST_CYCLES = 10 + 40 + 20 + 25 + 110 + 50;

	logic        clock;
	logic        reset_n;
	bus_req_t    core_req;
	bus_req_t    cs_req;
	cache_evt_t  cache_evt;
	logic [31:0] core_rdata;
	logic [31:0] cs_rdata;
	phase_word_t phase;
	comm_word_t  comm;

	// reference model state
	logic [31:0] m_mbox [3];
	comm_word_t  m_comm;
	phase_word_t m_phase;
	logic [1:0]  m_metric;
	logic [31:0] m_core_rd;
	logic [31:0] m_cs_rd;
	logic [31:0] m_evt_cnt;
	logic [31:0] m_cyc_cnt;
	logic        model_ready = 1'b0;

	logic [31:0] lcg_state;
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) clock_gen0 (
		.clock_o (clock),
		.reset_o (reset_n)
	);

	peripheral_subsystem dut0 (
		.clock_i      (clock),
		.reset_i      (reset_n),
		.core_req_i   (core_req),
		.core_rdata_o (core_rdata),
		.cs_req_i     (cs_req),
		.cs_rdata_o   (cs_rdata),
		.cache_evt_i  (cache_evt),
		.phase_o      (phase),
		.comm_o       (comm)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// expected core read data
	// unmapped addresses keep the old data
	function automatic logic [31:0] core_read_value(input logic [`PERIPH_ADDR_W-1:0] addr,
			input logic [31:0] old);
		case (addr)
			`COMM_REGISTER0: return m_mbox[0];
			`COMM_REGISTER1: return m_mbox[1];
			`COMM_REGISTER2: return m_mbox[2];
			default:         return old;
		endcase
	endfunction

	function automatic logic [31:0] cs_read_value(input logic [`PERIPH_ADDR_W-1:0] addr);
		case (addr)
			`COMM_REGISTER0: return m_mbox[0];
			`COMM_REGISTER1: return m_mbox[1];
			`COMM_REGISTER2: return m_mbox[2];
			`COMM_CACHE0:    return m_evt_cnt;
			`COMM_CACHE1:    return m_cyc_cnt;
			default:         return 32'd0;
		endcase
	endfunction

	function automatic logic selected_event(input logic [1:0] metric, input cache_evt_t evt);
		case (metric)
			2'd0:    return evt.hit;
			2'd1:    return evt.miss;
			2'd2:    return evt.writeback;
			default: return evt.hit | evt.miss | evt.writeback;
		endcase
	endfunction

	// one clock edge of the model
	// reads and counters see the old state
	task automatic step_model();
		if (!reset_n) begin
			m_mbox[0] = '0;
			m_mbox[1] = '0;
			m_mbox[2] = '0;
			m_comm    = '0;
			m_phase   = '0;
			m_metric  = 2'd0;
			m_core_rd = `PERIPH_READ_RESET;
			m_cs_rd   = `PERIPH_READ_RESET;
			m_evt_cnt = '0;
			m_cyc_cnt = '0;
		end else begin
			if (core_req.req && !core_req.rw)
				m_core_rd = core_read_value(core_req.addr, m_core_rd);
			if (cs_req.req && !cs_req.rw)
				m_cs_rd = cs_read_value(cs_req.addr);
			if (m_comm.cs_ctrl[23]) begin
				m_evt_cnt = '0;
				m_cyc_cnt = '0;
			end else begin
				m_evt_cnt = m_evt_cnt + {31'd0, selected_event(m_metric, cache_evt)};
				m_cyc_cnt = m_cyc_cnt + 32'd1;
			end
			m_comm.cs_ctrl[23] = 1'b0;
			m_phase.marker     = 1'b0;
			if (core_req.req && core_req.rw) begin
				case (core_req.addr)
					`COMM_REGISTER0: m_mbox[0] = core_req.wdata;
					`COMM_REGISTER1: m_mbox[1] = core_req.wdata;
					`COMM_REGISTER2: m_mbox[2] = core_req.wdata;
					`COMM_CONTROL:   m_comm.pro_ctrl = core_req.wdata[7:0];
					`PHASE_REG:      m_phase = {1'b1, core_req.wdata[30:0]};
					default: ;
				endcase
			end
			if (cs_req.req && cs_req.rw) begin
				case (cs_req.addr)
					`COMM_CONTROL:      m_comm.cs_ctrl = cs_req.wdata[23:0];
					`CPC_METRIC_SWITCH: m_metric = cs_req.wdata[1:0];
					default: ;
				endcase
			end
		end
	endtask

	task automatic flag_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("CHECK FAILED at %0t ns: %s expected %08h actual %08h",
			$time, name, expected, actual);
	endtask

	// outputs still hold their pre-edge values here
	always @(posedge clock) begin
		if (model_ready) begin
			assert (core_rdata === m_core_rd)
				else flag_mismatch("core_rdata_o", m_core_rd, core_rdata);
			assert (cs_rdata === m_cs_rd)
				else flag_mismatch("cs_rdata_o", m_cs_rd, cs_rdata);
			assert (comm === m_comm)
				else flag_mismatch("comm_o", m_comm, comm);
			assert (phase === m_phase)
				else flag_mismatch("phase_o", m_phase, phase);
		end
		step_model();
		model_ready = 1'b1;
	end

	function automatic bus_req_t make_req(input logic rw,
			input logic [`PERIPH_ADDR_W-1:0] addr, input logic [31:0] data);
		return {1'b1, rw, addr, data};
	endfunction

	function automatic logic [`PERIPH_ADDR_W-1:0] mbox_addr(input logic [31:0] r);
		if (r[9:8] == 2'd0)
			return `COMM_REGISTER0;
		else if (r[9:8] == 2'd1)
			return `COMM_REGISTER1;
		return `COMM_REGISTER2;
	endfunction

	// cache events stay random on every cycle
	task automatic drive_cycle(input bus_req_t core, input bus_req_t cs);
		logic [31:0] r;
		@(negedge clock);
		r         = lcg_next();
		core_req  = core;
		cs_req    = cs;
		cache_evt = r[18:16];
	endtask

	task automatic finish_test(input string name, input int errors_before);
		// two idle cycles so the last request reaches the checker
		repeat (2) drive_cycle('0, '0);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errors_before);
		end
	endtask

	initial begin
		int                        base;
		int                        i;
		logic [31:0]               r;
		logic [`PERIPH_ADDR_W-1:0] a;
		core_req  = '0;
		cs_req    = '0;
		cache_evt = '0;
		lcg_state = 32'd46;
		@(posedge reset_n);

		base = errors;
		repeat (2) drive_cycle('0, '0);
		drive_cycle(make_req(1'b0, 27'h4000000, '0), make_req(1'b0, `COMM_REGISTER1, '0));
		drive_cycle(make_req(1'b0, `COMM_REGISTER0, '0), make_req(1'b0, `COMM_REGISTER2, '0));
		finish_test("reset", base);

		// cs read in the write cycle returns the old word
		base = errors;
		for (i = 0; i < 12; i++) begin
			r = lcg_next();
			a = mbox_addr(r);
			drive_cycle(make_req(1'b1, a, lcg_next()), make_req(1'b0, a, '0));
			drive_cycle(make_req(1'b0, a, '0), make_req(1'b0, a, '0));
			drive_cycle(make_req(1'b0, {1'b1, r[25:0]}, '0), make_req(1'b0, {1'b1, r[26:1]}, '0));
		end
		finish_test("mailbox", base);

		base = errors;
		for (i = 0; i < 4; i++) begin
			r = lcg_next();
			drive_cycle(make_req(1'b1, `COMM_CONTROL, r),
				make_req(1'b1, `COMM_CONTROL, {8'h00, i[0], r[30:8]}));
			repeat (3) drive_cycle('0, '0);
		end
		finish_test("control", base);

		base = errors;
		for (i = 0; i < 4; i++) begin
			drive_cycle(make_req(1'b1, `PHASE_REG, lcg_next()), '0);
			repeat (2 + i) drive_cycle('0, '0);
		end
		drive_cycle(make_req(1'b1, `PHASE_REG, lcg_next()), '0);
		drive_cycle(make_req(1'b1, `PHASE_REG, lcg_next()), '0);
		finish_test("phase", base);

		// counts run on across a metric change and restart on the clear
		base = errors;
		for (i = 0; i < 4; i++) begin
			drive_cycle('0, make_req(1'b1, `CPC_METRIC_SWITCH, i));
			repeat (10) drive_cycle('0, '0);
			// the core port cannot see the cache words
			drive_cycle(make_req(1'b0, `COMM_CACHE0, '0), make_req(1'b0, `COMM_CACHE0, '0));
			drive_cycle('0, make_req(1'b0, `COMM_CACHE1, '0));
			drive_cycle('0, make_req(1'b1, `COMM_CONTROL, 32'h0080_0000));
			drive_cycle('0, make_req(1'b0, `COMM_CACHE1, '0));
			repeat (8) drive_cycle('0, '0);
			drive_cycle('0, make_req(1'b0, `COMM_CACHE0, '0));
			drive_cycle('0, make_req(1'b0, `COMM_CACHE1, '0));
		end
		finish_test("cache sampling", base);

		$display("tests passed %0d, failed %0d, mismatches %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clock_o,
	output logic reset_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD / 2) clock_o = ~clock_o;
	end

	// active low, released on a falling edge
	initial begin
		reset_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		@(negedge clock_o);
		reset_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/peripheral_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "peripheral_defs.svh"

module peripheral_subsystem
	import periph_bus_pkg::*;
	import comm_pkg::*;
(
	input  wire                       clock_i,
	input  wire                       reset_i,

	input  bus_req_t                  core_req_i,
	output logic [`PERIPH_DATA_W-1:0] core_rdata_o,

	input  bus_req_t                  cs_req_i,
	output logic [`PERIPH_DATA_W-1:0] cs_rdata_o,

	input  cache_evt_t                cache_evt_i,

	output phase_word_t               phase_o,
	output comm_word_t                comm_o
);

	metric_sel_e               metric_sel;
	logic [`PERIPH_DATA_W-1:0] cache0;
	logic [`PERIPH_DATA_W-1:0] cache1;

	comm_mailbox u_mailbox (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.core_req_i   (core_req_i),
		.core_rdata_o (core_rdata_o),
		.cs_req_i     (cs_req_i),
		.cs_rdata_o   (cs_rdata_o),
		.cache0_i     (cache0),
		.cache1_i     (cache1),
		.metric_sel_o (metric_sel),
		.phase_o      (phase_o),
		.comm_o       (comm_o)
	);

	// sampler clear comes from the top bit of the control system field
	cache_sampler u_sampler (
		.clock_i       (clock_i),
		.reset_i       (reset_i),
		.evt_i         (cache_evt_i),
		.metric_sel_i  (metric_sel),
		.clear_i       (comm_o.cs_ctrl[23]),
		.event_count_o (cache0),
		.cycle_count_o (cache1)
	);

endmodule

`default_nettype wire

//--- verilog/cache_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module cache_sampler
	import comm_pkg::*;
(
	input  wire         clock_i,
	input  wire         reset_i,

	// event strobes from the cache
	input  cache_evt_t  evt_i,
	input  metric_sel_e metric_sel_i,

	// one cycle clear from the control word
	input  wire         clear_i,

	output logic [31:0] event_count_o,
	output logic [31:0] cycle_count_o
);

	logic        evt_sel;
	logic [31:0] event_cnt_q;
	logic [31:0] cycle_cnt_q;

	// pick the event class to count
	always_comb begin
		case (metric_sel_i)
			METRIC_HIT:       evt_sel = evt_i.hit;
			METRIC_MISS:      evt_sel = evt_i.miss;
			METRIC_WRITEBACK: evt_sel = evt_i.writeback;
			// any access at all
			METRIC_ANY:       evt_sel = evt_i.hit | evt_i.miss | evt_i.writeback;
			default:          evt_sel = 1'b0;
		endcase
	end

	// clear wins over counting
	// switching metric leaves the counts alone
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			event_cnt_q <= '0;
			cycle_cnt_q <= '0;
		end else if (clear_i) begin
			event_cnt_q <= '0;
			cycle_cnt_q <= '0;
		end else begin
			if (evt_sel)
				event_cnt_q <= event_cnt_q + 32'd1;
			// wraps at 32 bits
			cycle_cnt_q <= cycle_cnt_q + 32'd1;
		end
	end

	assign event_count_o = event_cnt_q;
	assign cycle_count_o = cycle_cnt_q;

endmodule

`default_nettype wire

//--- verilog/comm_mailbox.sv
`timescale 1ns/1ns
`default_nettype none

`include "peripheral_defs.svh"

module comm_mailbox
	import periph_bus_pkg::*;
	import comm_pkg::*;
(
	input  wire                       clock_i,
	input  wire                       reset_i,

	// core side
	input  bus_req_t                  core_req_i,
	output logic [`PERIPH_DATA_W-1:0] core_rdata_o,

	// control system side
	input  bus_req_t                  cs_req_i,
	output logic [`PERIPH_DATA_W-1:0] cs_rdata_o,

	// sampler interface
	input  wire  [`PERIPH_DATA_W-1:0] cache0_i,
	input  wire  [`PERIPH_DATA_W-1:0] cache1_i,
	output metric_sel_e               metric_sel_o,

	output phase_word_t               phase_o,
	output comm_word_t                comm_o
);

	logic [`PERIPH_DATA_W-1:0] mbox0_q;
	logic [`PERIPH_DATA_W-1:0] mbox1_q;
	logic [`PERIPH_DATA_W-1:0] mbox2_q;
	comm_word_t                comm_q;
	phase_word_t               phase_q;
	metric_sel_e               metric_sel_q;

	logic core_wr;
	logic core_rd;
	logic cs_wr;
	logic cs_rd;

	assign core_wr = core_req_i.req & core_req_i.rw;
	assign core_rd = core_req_i.req & ~core_req_i.rw;
	assign cs_wr   = cs_req_i.req & cs_req_i.rw;
	assign cs_rd   = cs_req_i.req & ~cs_req_i.rw;

	assign comm_o       = comm_q;
	assign phase_o      = phase_q;
	assign metric_sel_o = metric_sel_q;

	// write decode for both ports
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			mbox0_q      <= '0;
			mbox1_q      <= '0;
			mbox2_q      <= '0;
			comm_q       <= '0;
			phase_q      <= '0;
			metric_sel_q <= METRIC_HIT;
		end else begin
			// pulse bits drop one cycle after being set
			// a write in the same cycle takes precedence
			if (comm_q.cs_ctrl[23])
				comm_q.cs_ctrl[23] <= 1'b0;
			if (phase_q.marker)
				phase_q.marker <= 1'b0;

			if (core_wr) begin
				case (core_req_i.addr)
					`COMM_REGISTER0: mbox0_q <= core_req_i.wdata;
					`COMM_REGISTER1: mbox1_q <= core_req_i.wdata;
					`COMM_REGISTER2: mbox2_q <= core_req_i.wdata;
					`COMM_CONTROL:   comm_q.pro_ctrl <= core_req_i.wdata[7:0];
					// new phase raises the marker
					`PHASE_REG: begin
						phase_q.marker <= 1'b1;
						phase_q.phase  <= core_req_i.wdata[30:0];
					end
					default: ;
				endcase
			end

			if (cs_wr) begin
				case (cs_req_i.addr)
					`COMM_CONTROL:      comm_q.cs_ctrl <= cs_req_i.wdata[23:0];
					`CPC_METRIC_SWITCH: metric_sel_q <= metric_sel_e'(cs_req_i.wdata[1:0]);
					default: ;
				endcase
			end
		end
	end

	// core read path, unmapped addresses keep the old data
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			core_rdata_o <= `PERIPH_READ_RESET;
		end else if (core_rd) begin
			case (core_req_i.addr)
				`COMM_REGISTER0: core_rdata_o <= mbox0_q;
				`COMM_REGISTER1: core_rdata_o <= mbox1_q;
				`COMM_REGISTER2: core_rdata_o <= mbox2_q;
				default: ;
			endcase
		end
	end

	// control system read path, also sees the cache statistics
	always_ff @(posedge clock_i) begin
		if (!reset_i) begin
			cs_rdata_o <= `PERIPH_READ_RESET;
		end else if (cs_rd) begin
			case (cs_req_i.addr)
				`COMM_REGISTER0: cs_rdata_o <= mbox0_q;
				`COMM_REGISTER1: cs_rdata_o <= mbox1_q;
				`COMM_REGISTER2: cs_rdata_o <= mbox2_q;
				`COMM_CACHE0:    cs_rdata_o <= cache0_i;
				`COMM_CACHE1:    cs_rdata_o <= cache1_i;
				default:         cs_rdata_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/comm_pkg.sv
`default_nettype none

package comm_pkg;

	// control register as seen by the external side
	typedef struct packed {
		// written by the core
		logic [7:0]  pro_ctrl;
		// written by the control system, bit 23 clears the sampler
		logic [23:0] cs_ctrl;
	} comm_word_t;

	// core phase word
	typedef struct packed {
		// one cycle pulse after each phase write
		logic        marker;
		logic [30:0] phase;
	} phase_word_t;

	// which cache event class the sampler counts
	typedef enum logic [1:0] {
		METRIC_HIT       = 2'd0,
		METRIC_MISS      = 2'd1,
		METRIC_WRITEBACK = 2'd2,
		METRIC_ANY       = 2'd3
	} metric_sel_e;

	// one strobe per event class per cycle
	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} cache_evt_t;

endpackage

`default_nettype wire

//--- verilog/periph_bus_pkg.sv
`default_nettype none

package periph_bus_pkg;

	// plain strobe bus, no handshake
	// a request is served in the cycle it is high
	typedef struct packed {
		// request strobe
		logic        req;
		// 1 = write, 0 = read
		logic        rw;
		// word address
		logic [26:0] addr;
		// write data, ignored on reads
		logic [31:0] wdata;
	} bus_req_t;

endpackage

`default_nettype wire

//--- include/peripheral_defs.svh
`ifndef PERIPHERAL_DEFS_SVH
`define PERIPHERAL_DEFS_SVH

// bus widths
`define PERIPH_ADDR_W 27
`define PERIPH_DATA_W 32

// shared mailbox registers, visible to both ports
`define COMM_REGISTER0 27'h0000010
`define COMM_REGISTER1 27'h0000014
`define COMM_REGISTER2 27'h0000018

// core writes the top byte, control system the low 24 bits
`define COMM_CONTROL 27'h000001C

// core phase word, bit 31 is the phase marker
`define PHASE_REG 27'h0000020

// cache sampler metric selection, control system side
`define CPC_METRIC_SWITCH 27'h0000024

// cache statistics, read only from the control system
`define COMM_CACHE0 27'h0000028
`define COMM_CACHE1 27'h000002C

// read data seen before the first read after reset
`define PERIPH_READ_RESET 32'hDEADBEAF

`endif
